//--- decode_pkg.sv
package decode_pkg;

//////////////////////////////
// major opcodes and control enums
//////////////////////////////

typedef enum logic [6:0] {
    OPCODE_OP     = 7'b0110011,
    OPCODE_OP_IMM = 7'b0010011,
    OPCODE_LUI    = 7'b0110111,
    OPCODE_AUIPC  = 7'b0010111,
    OPCODE_LOAD   = 7'b0000011,
    OPCODE_STORE  = 7'b0100011,
    OPCODE_BRANCH = 7'b1100011,
    OPCODE_JAL    = 7'b1101111,
    OPCODE_JALR   = 7'b1100111,
    OPCODE_SYSTEM = 7'b1110011
} opcode_t;

typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL,
    ALU_SRA, ALU_SLT, ALU_SLTU, ALU_SEQ, ALU_SNE, ALU_SGE, ALU_SGEU
} alu_op_t;

typedef enum logic [1:0] {ALU_SCR1_RS1, ALU_SCR1_PC, ALU_SCR1_ZERO, ALU_SCR1_IMM_CSR} alu_src1_t;
typedef enum logic [1:0] {ALU_SCR2_RS2, ALU_SCR2_IMM, ALU_SCR2_FOUR} alu_src2_t;
typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_t;
typedef enum logic [1:0] {BYTE, HALF_WORD, WORD} data_type_t;
typedef enum logic [1:0] {PC_NEXT, PC_JAL, PC_JALR, PC_BRANCH} pc_src_t;
typedef enum logic [1:0] {CSR_READ, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_t;

typedef logic [4:0] reg_addr_t;

//////////////////////////////
// instruction word formats
//////////////////////////////

typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
} r_fmt_t;

typedef struct packed {
    logic [11:0] imm12;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
} i_fmt_t;

typedef struct packed {
    logic [6:0] imm_hi; // imm[11:5]
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo; // imm[4:0]
    logic [6:0] opcode;
} s_fmt_t;

typedef struct packed {
    logic [19:0] imm20;
    reg_addr_t   rd;
    logic [6:0]  opcode;
} u_fmt_t;

typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
} instr_word_u;

typedef struct packed {
    alu_op_t    alu_op;
    alu_src1_t  src1;
    alu_src2_t  src2;
    imm_kind_t  imm_kind;
    logic       mem_wen;
    data_type_t mem_type;
    logic       mem_sign_ext;
    logic       reg_alu_wen;
    logic       reg_mem_wen;
    pc_src_t    pc_src;
    logic       is_branch;
    logic       csr_access;
    csr_op_t    csr_op;
    logic       is_mret;
    logic       illegal;
} decode_ctrl_t;

typedef struct packed {
    decode_ctrl_t ctrl;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
} decoded_t;

// nop-like control word with every enable low
localparam decode_ctrl_t CTRL_DEFAULT = '{
    alu_op: ALU_ADD, src1: ALU_SCR1_RS1, src2: ALU_SCR2_RS2, imm_kind: IMM_I,
    mem_wen: 1'b0, mem_type: WORD, mem_sign_ext: 1'b0, reg_alu_wen: 1'b0,
    reg_mem_wen: 1'b0, pc_src: PC_NEXT, is_branch: 1'b0, csr_access: 1'b0,
    csr_op: CSR_READ, is_mret: 1'b0, illegal: 1'b0
};

// flow control depths
localparam int IN_QUEUE_DEPTH = 2;
localparam int OUT_CREDITS    = 2;
localparam int QPTR_W         = $clog2(IN_QUEUE_DEPTH);
localparam int QCNT_W         = $clog2(IN_QUEUE_DEPTH + 1);
localparam int CREDIT_CNT_W   = $clog2(OUT_CREDITS + 1);

// machine mode csr map
localparam logic [11:0] CSR_MSTATUS   = 12'h300;
localparam logic [11:0] CSR_MISA      = 12'h301;
localparam logic [11:0] CSR_MIE       = 12'h304;
localparam logic [11:0] CSR_MTVEC     = 12'h305;
localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
localparam logic [11:0] CSR_MEPC      = 12'h341;
localparam logic [11:0] CSR_MCAUSE    = 12'h342;
localparam logic [11:0] CSR_MVENDORID = 12'hF11;
localparam logic [11:0] CSR_MARCHID   = 12'hF12;
localparam logic [11:0] CSR_MIMPID    = 12'hF13;
localparam logic [11:0] CSR_MHARTID   = 12'hF14;

endpackage

//--- instr_queue.sv
`timescale 1ns/1ns

module instr_queue import decode_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        push_i,
    input  instr_word_u instr_i,
    input  logic        pop_i,
    output instr_word_u head_o,
    output logic        head_valid_o
);

instr_word_u       slots [IN_QUEUE_DEPTH];
logic [QPTR_W-1:0] wr_ptr_q;
logic [QPTR_W-1:0] rd_ptr_q;
logic [QCNT_W-1:0] count_q;

always_ff @(posedge clk_i) begin
    if (push_i)
        slots[wr_ptr_q] <= instr_i;
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
    end else begin
        if (push_i)
            wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
        if (pop_i)
            rd_ptr_q <= rd_ptr_q + 1'b1;
        case ({push_i, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q; // none, or both at once
        endcase
    end
end

assign head_o       = slots[rd_ptr_q];
assign head_valid_o = (count_q != '0);

endmodule

//--- alu_decode.sv
`timescale 1ns/1ns

module alu_decode import decode_pkg::*; (
    input  instr_word_u  instr_i,
    output decode_ctrl_t ctrl_o
);

// opcode bit 2 picks the U-type pair, bit 5 splits each pair
always_comb begin
    ctrl_o             = CTRL_DEFAULT;
    ctrl_o.reg_alu_wen = 1'b1;

    if (instr_i.u.opcode[2]) begin
        // lui adds to zero, auipc adds to pc
        ctrl_o.src1     = instr_i.u.opcode[5] ? ALU_SCR1_ZERO : ALU_SCR1_PC;
        ctrl_o.src2     = ALU_SCR2_IMM;
        ctrl_o.imm_kind = IMM_U;
    end else if (instr_i.r.opcode[5]) begin // register-register
        if (!(instr_i.r.funct7 inside {7'h00, 7'h20}))
            ctrl_o.illegal = 1'b1;

        if (!instr_i.r.funct7[5]) begin
            case (instr_i.r.funct3)
                3'b000: ctrl_o.alu_op = ALU_ADD;
                3'b001: ctrl_o.alu_op = ALU_SLL;
                3'b010: ctrl_o.alu_op = ALU_SLT;
                3'b011: ctrl_o.alu_op = ALU_SLTU;
                3'b100: ctrl_o.alu_op = ALU_XOR;
                3'b101: ctrl_o.alu_op = ALU_SRL;
                3'b110: ctrl_o.alu_op = ALU_OR;
                default: ctrl_o.alu_op = ALU_AND;
            endcase
        end else begin
            case (instr_i.r.funct3)
                3'b000:  ctrl_o.alu_op = ALU_SUB;
                3'b101:  ctrl_o.alu_op = ALU_SRA;
                default: ctrl_o.illegal = 1'b1; // no alternate form
            endcase
        end
    end else begin // register-immediate
        ctrl_o.src2 = ALU_SCR2_IMM;
        case (instr_i.i.funct3)
            3'b000: ctrl_o.alu_op = ALU_ADD;
            3'b010: ctrl_o.alu_op = ALU_SLT;
            3'b011: ctrl_o.alu_op = ALU_SLTU;
            3'b100: ctrl_o.alu_op = ALU_XOR;
            3'b110: ctrl_o.alu_op = ALU_OR;
            3'b111: ctrl_o.alu_op = ALU_AND;
            3'b001: begin
                ctrl_o.alu_op  = ALU_SLL;
                ctrl_o.illegal = (instr_i.i.imm12[11:5] != 7'h00);
            end
            default: begin // srli / srai share funct3
                ctrl_o.alu_op  = instr_i.i.imm12[10] ? ALU_SRA : ALU_SRL;
                ctrl_o.illegal = !(instr_i.i.imm12[11:5] inside {7'h00, 7'h20});
            end
        endcase
    end
end

endmodule

//--- mem_decode.sv
`timescale 1ns/1ns

module mem_decode import decode_pkg::*; (
    input  instr_word_u  instr_i,
    output decode_ctrl_t ctrl_o
);

// address is always rs1 + imm
always_comb begin
    ctrl_o        = CTRL_DEFAULT;
    ctrl_o.alu_op = ALU_ADD;
    ctrl_o.src2   = ALU_SCR2_IMM;

    if (instr_i.s.opcode[5]) begin // store
        ctrl_o.imm_kind = IMM_S;
        ctrl_o.mem_wen  = 1'b1;
        case (instr_i.s.funct3)
            3'b000:  ctrl_o.mem_type = BYTE;
            3'b001:  ctrl_o.mem_type = HALF_WORD;
            3'b010:  ctrl_o.mem_type = WORD;
            default: ctrl_o.illegal  = 1'b1;
        endcase
    end else begin // load
        ctrl_o.imm_kind     = IMM_I;
        ctrl_o.reg_mem_wen  = 1'b1;
        ctrl_o.mem_sign_ext = !instr_i.i.funct3[2]; // lbu/lhu zero extend
        case (instr_i.i.funct3)
            3'b000, 3'b100: ctrl_o.mem_type = BYTE;
            3'b001, 3'b101: ctrl_o.mem_type = HALF_WORD;
            3'b010:         ctrl_o.mem_type = WORD;
            default:        ctrl_o.illegal  = 1'b1;
        endcase
    end
end

endmodule

//--- flow_decode.sv
`timescale 1ns/1ns

module flow_decode import decode_pkg::*; (
    input  instr_word_u  instr_i,
    output decode_ctrl_t ctrl_o
);

// targets come from a separate adder, the alu only compares or links
always_comb begin
    ctrl_o = CTRL_DEFAULT;

    if (!instr_i.i.opcode[2]) begin // branch
        ctrl_o.imm_kind  = IMM_B;
        ctrl_o.pc_src    = PC_BRANCH;
        ctrl_o.is_branch = 1'b1;
        case (instr_i.i.funct3)
            3'b000:  ctrl_o.alu_op  = ALU_SEQ;
            3'b001:  ctrl_o.alu_op  = ALU_SNE;
            3'b100:  ctrl_o.alu_op  = ALU_SLT;
            3'b101:  ctrl_o.alu_op  = ALU_SGE;
            3'b110:  ctrl_o.alu_op  = ALU_SLTU;
            3'b111:  ctrl_o.alu_op  = ALU_SGEU;
            default: ctrl_o.illegal = 1'b1;
        endcase
    end else begin
        // link value pc + 4
        ctrl_o.src1        = ALU_SCR1_PC;
        ctrl_o.src2        = ALU_SCR2_FOUR;
        ctrl_o.reg_alu_wen = 1'b1;
        if (instr_i.i.opcode[3]) begin // jal
            ctrl_o.imm_kind = IMM_J;
            ctrl_o.pc_src   = PC_JAL;
        end else begin // jalr
            ctrl_o.imm_kind = IMM_I;
            ctrl_o.pc_src   = PC_JALR;
            ctrl_o.illegal  = (instr_i.i.funct3 != 3'b000);
        end
    end
end

endmodule

//--- system_decode.sv
`timescale 1ns/1ns

module system_decode import decode_pkg::*; (
    input  instr_word_u  instr_i,
    output decode_ctrl_t ctrl_o
);

logic rs1_zero;

assign rs1_zero = (instr_i.i.rs1 == '0); // set/clear with x0 only reads

always_comb begin
    ctrl_o = CTRL_DEFAULT;

    if (instr_i.i.funct3 == 3'b000) begin
        // only mret is supported here
        if (instr_i.i.imm12 == 12'h302 && {instr_i.i.rs1, instr_i.i.rd} == '0)
            ctrl_o.is_mret = 1'b1;
        else
            ctrl_o.illegal = 1'b1;
    end else begin
        ctrl_o.csr_access  = 1'b1;
        ctrl_o.reg_alu_wen = 1'b1;
        ctrl_o.src2        = ALU_SCR2_IMM;
        if (instr_i.i.funct3[2])
            ctrl_o.src1 = ALU_SCR1_IMM_CSR; // zimm in rs1 field

        case (instr_i.i.funct3[1:0])
            2'b01:   ctrl_o.csr_op  = CSR_WRITE;
            2'b10:   ctrl_o.csr_op  = rs1_zero ? CSR_READ : CSR_SET;
            2'b11:   ctrl_o.csr_op  = rs1_zero ? CSR_READ : CSR_CLEAR;
            default: ctrl_o.illegal = 1'b1; // funct3 = 100
        endcase

        //////////////////////////////
        // csr address legality
        //////////////////////////////
        case (instr_i.i.imm12)
            CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC,
            CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE: ;

            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID: begin
                if (ctrl_o.csr_op != CSR_READ)
                    ctrl_o.illegal = 1'b1; // read-only ids
            end

            default: ctrl_o.illegal = 1'b1;
        endcase
    end
end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ns

module decode_stage import decode_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    output logic        credit_o,
    input  logic        credit_i,
    output logic        out_valid_o,
    output decoded_t    decoded_o
);

instr_word_u             head;
logic                    head_valid;
logic                    pop;
logic [CREDIT_CNT_W-1:0] out_credits_q;
decode_ctrl_t            alu_ctrl, mem_ctrl, flow_ctrl, sys_ctrl;
decode_ctrl_t            ctrl;
decoded_t                decoded;

instr_queue instr_queue_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (instr_valid_i),
    .instr_i      (instr_i),
    .pop_i        (pop),
    .head_o       (head),
    .head_valid_o (head_valid)
);

alu_decode    alu_decode_i    (.instr_i(head), .ctrl_o(alu_ctrl));
mem_decode    mem_decode_i    (.instr_i(head), .ctrl_o(mem_ctrl));
flow_decode   flow_decode_i   (.instr_i(head), .ctrl_o(flow_ctrl));
system_decode system_decode_i (.instr_i(head), .ctrl_o(sys_ctrl));

//////////////////////////////
// opcode dispatch
//////////////////////////////
always_comb begin
    ctrl = CTRL_DEFAULT;
    case (head.u.opcode)
        OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI, OPCODE_AUIPC: ctrl = alu_ctrl;
        OPCODE_LOAD, OPCODE_STORE:                          ctrl = mem_ctrl;
        OPCODE_BRANCH, OPCODE_JAL, OPCODE_JALR:             ctrl = flow_ctrl;
        OPCODE_SYSTEM:                                      ctrl = sys_ctrl;
        default:                                            ctrl.illegal = 1'b1;
    endcase
end

assign decoded = '{ctrl: ctrl, rs1: head.r.rs1, rs2: head.r.rs2, rd: head.u.rd};

assign pop = head_valid && (out_credits_q != '0); // needs a slot downstream

//////////////////////////////
// output register and credits
//////////////////////////////
always_ff @(posedge clk_i) begin
    if (pop)
        decoded_o <= decoded;
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        out_valid_o   <= 1'b0;
        credit_o      <= 1'b0;
        out_credits_q <= CREDIT_CNT_W'(OUT_CREDITS);
    end else begin
        out_valid_o <= pop;
        credit_o    <= pop; // freed queue slot goes back to fetch
        case ({pop, credit_i})
            2'b10:   out_credits_q <= out_credits_q - 1'b1;
            2'b01:   out_credits_q <= out_credits_q + 1'b1;
            default: out_credits_q <= out_credits_q;
        endcase
    end
end

endmodule

//--- decode_stage_properties.sv
`timescale 1ns/1ns

module decode_stage_properties import decode_pkg::*; (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    push_i,
    input logic [QCNT_W-1:0]       queue_count_i,
    input logic [CREDIT_CNT_W-1:0] out_credits_i,
    input logic                    out_valid_i,
    input logic                    fetch_credit_i
);

// a result is only registered while a credit was held
out_valid_needs_credit: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i |-> $past(out_credits_i) != '0
) else $error("out_valid_o raised with no output credit");

no_push_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> queue_count_i != QCNT_W'(IN_QUEUE_DEPTH)
) else $error("push into a full instruction queue");

quiet_in_reset: assert property (
    @(posedge clk_i) !rst_n_i |=> !out_valid_i && !fetch_credit_i
) else $error("out_valid_o or credit_o high during reset");

endmodule

bind decode_stage decode_stage_properties decode_stage_properties_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .push_i         (instr_valid_i),
    .queue_count_i  (instr_queue_i.count_q),
    .out_credits_i  (out_credits_q),
    .out_valid_i    (out_valid_o),
    .fetch_credit_i (credit_o)
);

//--- tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage import decode_pkg::*; ();

localparam int N_INSTR        = 300;
localparam int RESET_CYCLES   = 10;
localparam int DRAIN_CYCLES   = 12;
localparam int TIMEOUT_CYCLES = N_INSTR * 8 + RESET_CYCLES;

localparam alu_op_t R_OPS [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                  ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
localparam logic [11:0] CSR_LIST [11] = '{CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC,
                                          CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MVENDORID,
                                          CSR_MARCHID, CSR_MIMPID, CSR_MHARTID};

logic        clk_i;
logic        rst_n_i;
logic        instr_valid_i;
logic [31:0] instr_i;
logic        credit_o;
logic        credit_i;
logic        out_valid_o;
decoded_t    decoded_o;

logic [15:0] lfsr_q = 16'd80;
decoded_t    exp_q [$];   // expected results in fetch order
int fetch_credits = IN_QUEUE_DEPTH;
int granted       = OUT_CREDITS;
int owed          = 0;  // credits execute still has to return
int sent          = 0;
int received      = 0;
int credit_pulses = 0;
int cycles        = 0;
int value_errors    = 0;
int protocol_errors = 0;
logic sending = 1'b0;

decode_stage decode_stage_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .credit_o     (credit_o),
    .credit_i     (credit_i),
    .out_valid_o  (out_valid_o),
    .decoded_o    (decoded_o)
);

always #20 clk_i = ~clk_i;

always @(posedge clk_i) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
        $display("timeout after %0d cycles with %0d of %0d results received",
                 cycles, received, N_INSTR);
        $display("Test failures found");
        $finish;
    end
end

//////////////////////////////
// random numbers
//////////////////////////////
function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]; // x^16+x^14+x^13+x^11+1
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
        v = {v[30:0], lfsr_bit()};
    return v;
endfunction

function automatic logic known_opcode(logic [6:0] op);
    return op inside {OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI, OPCODE_AUIPC, OPCODE_LOAD,
                      OPCODE_STORE, OPCODE_BRANCH, OPCODE_JAL, OPCODE_JALR, OPCODE_SYSTEM};
endfunction

//////////////////////////////
// instruction templates
//////////////////////////////
function automatic logic [31:0] make_instr();
    logic [31:0] w;
    int          sel;
    sel = rand_bits(4) % 11;
    w   = rand_bits(32);
    case (sel)
        0, 1: begin
            w[6:0] = (sel == 0) ? OPCODE_OP : OPCODE_OP_IMM;
            if (rand_bits(2) != 0)
                w[31:25] = {1'b0, w[30], 5'b0}; // mostly legal funct7
        end
        2: w[6:0] = OPCODE_LUI;
        3: w[6:0] = OPCODE_AUIPC;
        4: w[6:0] = OPCODE_LOAD;
        5: w[6:0] = OPCODE_STORE;
        6: w[6:0] = OPCODE_BRANCH;
        7: w[6:0] = OPCODE_JAL;
        8: begin
            w[6:0] = OPCODE_JALR;
            if (lfsr_bit())
                w[14:12] = 3'b000;
        end
        9: begin
            w[6:0] = OPCODE_SYSTEM;
            if (rand_bits(3) == 0) begin
                w = 32'h3020_0073; // mret
            end else begin
                sel = rand_bits(4);
                if (sel < 11)
                    w[31:20] = CSR_LIST[sel]; // otherwise a random address
                if (lfsr_bit())
                    w[19:15] = 5'd0;
            end
        end
        default: begin
            w[6:0] = rand_bits(7);
            while (known_opcode(w[6:0]))
                w[6:0] = rand_bits(7);
        end
    endcase
    return w;
endfunction

//////////////////////////////
// reference model
//////////////////////////////
function automatic decoded_t model_decode(logic [31:0] w);
    decode_ctrl_t c;
    logic [2:0]   f3;
    logic [6:0]   f7;
    logic         id_csr;
    logic         rw_csr;
    f3         = w[14:12];
    f7         = w[31:25];
    c          = '0;
    c.mem_type = WORD;
    case (w[6:0])
        OPCODE_OP: begin
            c.reg_alu_wen = 1'b1;
            c.illegal     = !(f7 == 7'h00 || f7 == 7'h20);
            if (!f7[5])
                c.alu_op = R_OPS[f3];
            else if (f3 == 3'b000)
                c.alu_op = ALU_SUB;
            else if (f3 == 3'b101)
                c.alu_op = ALU_SRA;
            else
                c.illegal = 1'b1;
        end
        OPCODE_OP_IMM: begin
            c.reg_alu_wen = 1'b1;
            c.src2        = ALU_SCR2_IMM;
            c.alu_op      = R_OPS[f3];
            if (f3 == 3'b001)
                c.illegal = (f7 != 7'h00);
            if (f3 == 3'b101) begin
                c.alu_op  = w[30] ? ALU_SRA : ALU_SRL;
                c.illegal = !(f7 == 7'h00 || f7 == 7'h20);
            end
        end
        OPCODE_LUI, OPCODE_AUIPC: begin
            c.reg_alu_wen = 1'b1;
            c.src1        = (w[6:0] == OPCODE_LUI) ? ALU_SCR1_ZERO : ALU_SCR1_PC;
            c.src2        = ALU_SCR2_IMM;
            c.imm_kind    = IMM_U;
        end
        OPCODE_LOAD: begin
            c.src2         = ALU_SCR2_IMM;
            c.reg_mem_wen  = 1'b1;
            c.mem_sign_ext = !f3[2];
            if (f3[1:0] == 2'b11 || f3 == 3'b110)
                c.illegal = 1'b1;
            else
                c.mem_type = data_type_t'(f3[1:0]);
        end
        OPCODE_STORE: begin
            c.src2     = ALU_SCR2_IMM;
            c.imm_kind = IMM_S;
            c.mem_wen  = 1'b1;
            if (f3 > 3'd2)
                c.illegal = 1'b1;
            else
                c.mem_type = data_type_t'(f3[1:0]);
        end
        OPCODE_BRANCH: begin
            c.imm_kind  = IMM_B;
            c.pc_src    = PC_BRANCH;
            c.is_branch = 1'b1;
            case (f3)
                3'd0:    c.alu_op = ALU_SEQ;
                3'd1:    c.alu_op = ALU_SNE;
                3'd4:    c.alu_op = ALU_SLT;
                3'd5:    c.alu_op = ALU_SGE;
                3'd6:    c.alu_op = ALU_SLTU;
                3'd7:    c.alu_op = ALU_SGEU;
                default: c.illegal = 1'b1;
            endcase
        end
        OPCODE_JAL, OPCODE_JALR: begin
            c.src1        = ALU_SCR1_PC;
            c.src2        = ALU_SCR2_FOUR; // link address
            c.reg_alu_wen = 1'b1;
            if (w[6:0] == OPCODE_JAL) begin
                c.imm_kind = IMM_J;
                c.pc_src   = PC_JAL;
            end else begin
                c.pc_src  = PC_JALR;
                c.illegal = (f3 != 3'b000);
            end
        end
        OPCODE_SYSTEM: begin
            if (f3 == 3'b000) begin
                if (w == 32'h3020_0073)
                    c.is_mret = 1'b1;
                else
                    c.illegal = 1'b1;
            end else begin
                c.csr_access  = 1'b1;
                c.reg_alu_wen = 1'b1;
                c.src2        = ALU_SCR2_IMM;
                c.src1        = f3[2] ? ALU_SCR1_IMM_CSR : ALU_SCR1_RS1;
                case (f3[1:0])
                    2'b01:   c.csr_op = CSR_WRITE;
                    2'b10:   c.csr_op = CSR_SET;
                    2'b11:   c.csr_op = CSR_CLEAR;
                    default: c.illegal = 1'b1;
                endcase
                if (f3[1] && w[19:15] == 5'd0)
                    c.csr_op = CSR_READ; // x0 source leaves the csr alone
                id_csr = w[31:20] inside {CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID};
                rw_csr = w[31:20] inside {CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC,
                                          CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE};
                if (!(id_csr || rw_csr) || (id_csr && c.csr_op != CSR_READ))
                    c.illegal = 1'b1;
            end
        end
        default: c.illegal = 1'b1;
    endcase
    return '{ctrl: c, rs1: w[19:15], rs2: w[24:20], rd: w[11:7]};
endfunction

//////////////////////////////
// compare tasks
//////////////////////////////
task automatic check_ctrl(string name, decode_ctrl_t got, decode_ctrl_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_regs(string name, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
        value_errors++;
        $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

// samples what the last edge produced and drives the next inputs
task automatic step_cycle();
    decoded_t exp_dec;
    @(posedge clk_i);
    #2;
    if (credit_o) begin
        fetch_credits++;
        credit_pulses++;
    end
    if (out_valid_o) begin
        received++;
        owed++;
        if (received > granted) begin
            protocol_errors++;
            $display("%0t: result %0d sent with only %0d credits granted", $time, received, granted);
        end
        if (exp_q.size() == 0) begin
            protocol_errors++;
            $display("%0t: result arrived with no instruction outstanding", $time);
        end else begin
            exp_dec = exp_q.pop_front();
            check_ctrl("decoded_o.ctrl", decoded_o.ctrl, exp_dec.ctrl);
            check_regs("decoded_o.rs1", decoded_o.rs1, exp_dec.rs1);
            check_regs("decoded_o.rs2", decoded_o.rs2, exp_dec.rs2);
            check_regs("decoded_o.rd", decoded_o.rd, exp_dec.rd);
        end
    end
    if (credit_i)
        granted++; // last cycle's credit is usable from now on
    credit_i = 1'b0;
    if (owed > 0 && lfsr_bit()) begin // random return delay
        credit_i = 1'b1;
        owed--;
    end
    instr_valid_i = 1'b0;
    if (sending && sent < N_INSTR && fetch_credits > 0 && rand_bits(2) != 0) begin
        instr_i       = make_instr();
        instr_valid_i = 1'b1;
        fetch_credits--;
        sent++;
        exp_q.push_back(model_decode(instr_i));
    end
endtask

initial begin
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    credit_i      = 1'b0;
    repeat (RESET_CYCLES) begin
        @(posedge clk_i);
        #2;
        if (out_valid_o === 1'b1 || credit_o === 1'b1) begin
            protocol_errors++;
            $display("%0t: out_valid_o or credit_o active during reset", $time);
        end
    end
    rst_n_i = 1'b1;
    sending = 1'b1;
    while (received < N_INSTR)
        step_cycle();
    sending = 1'b0;
    repeat (DRAIN_CYCLES)
        step_cycle(); // any stray result shows up here
    check_count("credit_o pulses", credit_pulses, sent);
    check_count("results received", received, N_INSTR);
    $display("errors: %0d value mismatches, %0d protocol errors", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0)
        $display("All tests passed!");
    else
        $display("Test failures found");
    $finish;
end

endmodule

//--- compile.f
decode_pkg.sv
instr_queue.sv
alu_decode.sv
mem_decode.sv
flow_decode.sv
system_decode.sv
decode_stage.sv
decode_stage_properties.sv
tb_decode_stage.sv
